// ==== fp_unit.f ====
+incdir+include
hw/fp_pkg.sv
hw/fp_apb_ctrl.sv
hw/fp_align.sv
hw/fp_mant_add.sv
hw/fp_round_norm.sv
hw/fp_unit.sv
test/fp_unit_tb.sv

// ==== hw/fp_align.sv ====
`timescale 1ns/10ps
// Stage one: operand ordering and significand alignment
// Normal operands only, exponent fields 0 and 31 are not handled
module fp_align (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             start,
    input  fp_pkg::fp16_t    op_a,
    input  fp_pkg::fp16_t    op_b,
    input  logic             sub,
    output logic             a_valid,
    output fp_pkg::exp_t     big_exp,
    output fp_pkg::sig_t     big_sig,
    output fp_pkg::ext_sig_t small_ext,
    output logic             res_sign,
    output logic             eff_sub
);
    import fp_pkg::*;

    logic        a_big;
    fp16_t       big_w;
    fp16_t       small_w;
    exp_t        diff;
    logic [24:0] shifted;
    ext_sig_t    small_d;

    always_comb begin
        // Subtract is add with b negated
        a_big   = (op_a[14:0] >= op_b[14:0]);
        big_w   = a_big ? op_a : {op_b[15] ^ sub, op_b[14:0]};
        small_w = a_big ? {op_b[15] ^ sub, op_b[14:0]} : op_a;
        diff    = big_w[14:10] - small_w[14:10];

        // Bits below R all fold into sticky
        shifted = {1'b1, small_w[9:0], 14'd0} >> diff;
        if (diff >= 5'd14) begin
            small_d = {14'd0, 1'b1};
        end else begin
            small_d = {1'b0, shifted[24:12], |shifted[11:0]};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_valid <= 1'b0;
        end else begin
            a_valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            big_exp   <= big_w[14:10];
            big_sig   <= {1'b1, big_w[9:0]};
            small_ext <= small_d;
            res_sign  <= big_w[15];
            eff_sub   <= big_w[15] ^ small_w[15];
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        a_valid |-> (big_exp != 5'd0) && (big_exp != 5'd31));

endmodule

// ==== hw/fp_apb_ctrl.sv ====
`timescale 1ns/10ps
// APB3 slave for the binary16 unit, one operation in flight at a time
// A RESULT read while busy is held with wait states until writeback
// pslverr on busy CMD writes, STATUS/RESULT writes and unmapped addresses
module fp_apb_ctrl (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [fp_pkg::APB_AW-1:0] paddr,
    input  logic [fp_pkg::APB_DW-1:0] pwdata,
    output logic [fp_pkg::APB_DW-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic                      start,
    output fp_pkg::fp16_t             op_a,
    output fp_pkg::fp16_t             op_b,
    output logic                      sub,
    input  logic                      r_valid,
    input  fp_pkg::fp16_t             r_result,
    input  logic                      r_overflow,
    input  logic                      r_underflow,
    input  logic                      r_zero
);
    import fp_pkg::*;

    ctrl_state_e state;
    fp16_t       result_q;
    logic        ovf_q;
    logic        unf_q;
    logic        zero_q;
    logic        access;
    logic        xfer;
    logic        sel_ops;
    logic        sel_cmd;
    logic        sel_stat;
    logic        sel_res;
    logic        bad_xfer;
    logic        cmd_go;
    logic        res_read;

    // ============================================================
    // Address decode and handshake
    // ============================================================
    assign access   = psel & penable;
    assign sel_ops  = (paddr == ADDR_OPERANDS);
    assign sel_cmd  = (paddr == ADDR_CMD);
    assign sel_stat = (paddr == ADDR_STATUS);
    assign sel_res  = (paddr == ADDR_RESULT);

    // Wait states only for a RESULT read while the pipeline runs
    assign pready = ~(access & ~pwrite & sel_res & (state == BUSY));
    assign xfer   = access & pready;

    assign bad_xfer = ~(sel_ops | sel_cmd | sel_stat | sel_res)
                    | (pwrite & (sel_stat | sel_res))
                    | (pwrite & sel_cmd & (state == BUSY));
    assign pslverr  = xfer & bad_xfer;

    // New command accepted unless one is still running
    assign cmd_go   = xfer & pwrite & sel_cmd & (state != BUSY);
    assign res_read = xfer & ~pwrite & sel_res;

    always_comb begin
        prdata = '0;
        case (paddr)
            ADDR_OPERANDS: prdata = {op_b, op_a};
            ADDR_CMD:      prdata = {31'd0, sub};
            ADDR_STATUS:   prdata = {27'd0, zero_q, unf_q, ovf_q,
                                     state == DONE, state == BUSY};
            ADDR_RESULT:   prdata = {16'd0, result_q};
            default:       prdata = '0;
        endcase
    end

    // Operand, command and result payload
    always_ff @(posedge clk) begin
        if (xfer & pwrite & sel_ops) begin
            op_a <= pwdata[15:0];
            op_b <= pwdata[31:16];
        end
        if (cmd_go) begin
            sub <= pwdata[0];
        end
        if (r_valid) begin
            result_q <= r_result;
        end
    end

    // ============================================================
    // Sequencing FSM and status flags
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            start  <= 1'b0;
            ovf_q  <= 1'b0;
            unf_q  <= 1'b0;
            zero_q <= 1'b0;
        end else begin
            start <= cmd_go;
            case (state)
                IDLE: if (cmd_go) state <= BUSY;
                BUSY: if (r_valid) state <= DONE;
                DONE: begin
                    if (cmd_go) begin
                        state <= BUSY;
                    end else if (res_read) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            // Flags live until the next command
            if (cmd_go) begin
                ovf_q  <= 1'b0;
                unf_q  <= 1'b0;
                zero_q <= 1'b0;
            end else if (r_valid) begin
                ovf_q  <= r_overflow;
                unf_q  <= r_underflow;
                zero_q <= r_zero;
            end
        end
    end

    // Writeback only for an issued command
    assert property (@(posedge clk) disable iff (!arst_n) r_valid |-> state == BUSY);
    assert property (@(posedge clk) disable iff (!arst_n)
        pslverr |-> psel && penable && pready);

endmodule

// ==== hw/fp_mant_add.sv ====
`timescale 1ns/10ps
// Stage two: significand add or subtract on the extended format
// Operands arrive ordered by magnitude so a difference never goes negative
module fp_mant_add (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             a_valid,
    input  fp_pkg::exp_t     big_exp,
    input  fp_pkg::sig_t     big_sig,
    input  fp_pkg::ext_sig_t small_ext,
    input  logic             res_sign,
    input  logic             eff_sub,
    output logic             m_valid,
    output fp_pkg::ext_sig_t m_sum,
    output fp_pkg::exp_t     m_exp,
    output logic             m_sign
);
    import fp_pkg::*;

    ext_sig_t big_ext;
    ext_sig_t sum_d;

    // Larger operand has no shifted-out bits
    assign big_ext = {1'b0, big_sig, 3'b000};
    assign sum_d   = eff_sub ? (big_ext - small_ext) : (big_ext + small_ext);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid <= 1'b0;
        end else begin
            m_valid <= a_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (a_valid) begin
            m_sum  <= sum_d;
            m_exp  <= big_exp;
            m_sign <= res_sign;
        end
    end

endmodule

// ==== hw/fp_pkg.sv ====
// Shared types and constants for the binary16 add/sub coprocessor
// Register map offsets are byte addresses on a 4-bit APB address
package fp_pkg;

    // APB bus widths
    localparam int APB_DW = 32;
    localparam int APB_AW = 4;

    // Sign, exponent, fraction packed as one half precision word
    typedef logic [15:0] fp16_t;
    // Biased exponent field
    typedef logic [4:0]  exp_t;
    // Significand with the hidden one
    typedef logic [10:0] sig_t;
    // Carry, 11 significand bits, guard, round, sticky
    typedef logic [14:0] ext_sig_t;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } ctrl_state_e;

    // ============================================================
    // Register map
    // ============================================================
    localparam logic [APB_AW-1:0] ADDR_OPERANDS = 4'h0;
    localparam logic [APB_AW-1:0] ADDR_CMD      = 4'h4;
    localparam logic [APB_AW-1:0] ADDR_STATUS   = 4'h8;
    localparam logic [APB_AW-1:0] ADDR_RESULT   = 4'hC;

    // Pipeline constants
    localparam int   PIPE_DEPTH = 3;
    localparam exp_t EXP_MAX    = 5'd30;

endpackage

// ==== hw/fp_round_norm.sv ====
`timescale 1ns/10ps
// Stage three: normalize, round to nearest even, range checks
// Overflow saturates to signed infinity, underflow flushes to +0
// Zero flag covers exact zero and flushed results
module fp_round_norm (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             m_valid,
    input  fp_pkg::ext_sig_t m_sum,
    input  fp_pkg::exp_t     m_exp,
    input  logic             m_sign,
    output logic             r_valid,
    output fp_pkg::fp16_t    r_result,
    output logic             r_overflow,
    output logic             r_underflow,
    output logic             r_zero
);
    import fp_pkg::*;

    logic [3:0]        lzc;
    logic              found;
    logic [13:0]       norm;
    logic signed [6:0] exp_n;
    logic signed [6:0] exp_f;
    logic              round_up;
    logic [11:0]       rnd;
    logic [9:0]        frac_f;
    fp16_t             result_d;
    logic              ovf_d;
    logic              unf_d;
    logic              zero_d;

    // Leading zeros below the carry bit
    always_comb begin
        lzc   = 4'd0;
        found = 1'b0;
        for (int i = 13; i >= 0; i--) begin
            if (m_sum[i]) begin
                found = 1'b1;
            end else if (!found) begin
                lzc = lzc + 4'd1;
            end
        end
    end

    // ============================================================
    // Normalize and round
    // ============================================================
    always_comb begin
        if (m_sum[14]) begin
            // Carry out, R and S merge into the new sticky
            norm  = {m_sum[14:2], m_sum[1] | m_sum[0]};
            exp_n = $signed({2'b00, m_exp}) + 7'sd1;
        end else begin
            norm  = m_sum[13:0] << lzc;
            exp_n = $signed({2'b00, m_exp}) - $signed({3'b000, lzc});
        end

        // Ties go to the even significand
        round_up = norm[2] & (norm[3] | norm[1] | norm[0]);
        rnd      = {1'b0, norm[13:3]} + {11'd0, round_up};
        exp_f    = exp_n + $signed({6'd0, rnd[11]});
        frac_f   = rnd[11] ? rnd[10:1] : rnd[9:0];

        ovf_d    = 1'b0;
        unf_d    = 1'b0;
        zero_d   = 1'b0;
        result_d = 16'h0000;
        if (m_sum == '0) begin
            zero_d = 1'b1;
        end else if (exp_f > $signed({2'b00, EXP_MAX})) begin
            ovf_d    = 1'b1;
            result_d = {m_sign, 5'h1f, 10'd0};
        end else if (exp_f < 7'sd1) begin
            unf_d  = 1'b1;
            zero_d = 1'b1;
        end else begin
            result_d = {m_sign, exp_f[4:0], frac_f};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r_valid <= 1'b0;
        end else begin
            r_valid <= m_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (m_valid) begin
            r_result    <= result_d;
            r_overflow  <= ovf_d;
            r_underflow <= unf_d;
            r_zero      <= zero_d;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        r_valid |-> (r_result[14:10] != 5'h1f) || r_overflow);

endmodule

// ==== hw/fp_unit.sv ====
`timescale 1ns/10ps
// Binary16 add/sub coprocessor with an APB3 slave port
// Normal operands only, one command at a time
module fp_unit (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [fp_pkg::APB_AW-1:0] paddr,
    input  logic [fp_pkg::APB_DW-1:0] pwdata,
    output logic [fp_pkg::APB_DW-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr
);
    import fp_pkg::*;

    // Controller to stage one
    logic     start;
    fp16_t    op_a;
    fp16_t    op_b;
    logic     sub;
    // Stage one to stage two
    logic     a_valid;
    exp_t     big_exp;
    sig_t     big_sig;
    ext_sig_t small_ext;
    logic     res_sign;
    logic     eff_sub;
    // Stage two to stage three
    logic     m_valid;
    ext_sig_t m_sum;
    exp_t     m_exp;
    logic     m_sign;
    // Writeback
    logic     r_valid;
    fp16_t    r_result;
    logic     r_overflow;
    logic     r_underflow;
    logic     r_zero;

    fp_apb_ctrl ctrl_i (
        .clk(clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .start(start), .op_a(op_a), .op_b(op_b), .sub(sub),
        .r_valid(r_valid), .r_result(r_result),
        .r_overflow(r_overflow), .r_underflow(r_underflow), .r_zero(r_zero)
    );

    fp_align align_i (
        .clk(clk), .arst_n(arst_n),
        .start(start), .op_a(op_a), .op_b(op_b), .sub(sub),
        .a_valid(a_valid), .big_exp(big_exp), .big_sig(big_sig),
        .small_ext(small_ext), .res_sign(res_sign), .eff_sub(eff_sub)
    );

    fp_mant_add add_i (
        .clk(clk), .arst_n(arst_n),
        .a_valid(a_valid), .big_exp(big_exp), .big_sig(big_sig),
        .small_ext(small_ext), .res_sign(res_sign), .eff_sub(eff_sub),
        .m_valid(m_valid), .m_sum(m_sum), .m_exp(m_exp), .m_sign(m_sign)
    );

    fp_round_norm round_i (
        .clk(clk), .arst_n(arst_n),
        .m_valid(m_valid), .m_sum(m_sum), .m_exp(m_exp), .m_sign(m_sign),
        .r_valid(r_valid), .r_result(r_result),
        .r_overflow(r_overflow), .r_underflow(r_underflow), .r_zero(r_zero)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the binary16 coprocessor testbench with Verilator, run it and
# decide the outcome from the simulation log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f fp_unit.f \
    --top-module fp_unit_tb \
    -Mdir obj_dir \
    -o fp_unit_sim

./obj_dir/fp_unit_sim | tee sim.log

if grep -qxF '** PASS **' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// ==== include/fp_ref_model.svh ====
// Reference model for binary16 add/sub, normal operands only
// Exact integer sum, then round to nearest even on 11 significant bits
// Zero flag is set for any zero result, exact or flushed
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// 32-bit LCG step, caller keeps the state
function automatic logic [31:0] lcg_next(input logic [31:0] seed);
    return seed * 32'd1664525 + 32'd1013904223;
endfunction

function automatic void ref_addsub(
    input  fp_pkg::fp16_t a,
    input  fp_pkg::fp16_t b,
    input  logic          sub,
    output fp_pkg::fp16_t res,
    output logic          ovf,
    output logic          unf,
    output logic          zero
);
    int     ea;
    int     eb;
    int     emin;
    int     p;
    int     e;
    longint ma;
    longint mb;
    longint s;
    longint keep;
    longint rem;
    longint half;
    logic   sgn;

    ea   = int'(a[14:10]);
    eb   = int'(b[14:10]);
    emin = (ea < eb) ? ea : eb;
    // Both significands scaled to the smaller exponent
    ma   = longint'({1'b1, a[9:0]}) << (ea - emin);
    mb   = longint'({1'b1, b[9:0]}) << (eb - emin);
    if (a[15]) ma = -ma;
    if (b[15] ^ sub) mb = -mb;
    s    = ma + mb;
    res  = 16'h0000;
    ovf  = 1'b0;
    unf  = 1'b0;
    zero = 1'b0;
    if (s == 0) begin
        zero = 1'b1;
        return;
    end
    sgn = (s < 0);
    if (sgn) s = -s;
    p = 0;
    while ((s >> (p + 1)) != 0) begin
        p++;
    end
    e = p + emin - 10;
    if (p > 10) begin
        keep = s >> (p - 10);
        rem  = s - (keep << (p - 10));
        half = longint'(1) << (p - 11);
        if (rem > half || (rem == half && keep[0])) keep++;
        if (keep == 2048) begin
            keep = 1024;
            e++;
        end
    end else begin
        keep = s << (10 - p);
    end
    if (e > int'(fp_pkg::EXP_MAX)) begin
        ovf = 1'b1;
        res = {sgn, 5'h1f, 10'd0};
    end else if (e < 1) begin
        unf  = 1'b1;
        zero = 1'b1;
    end else begin
        res = {sgn, e[4:0], keep[9:0]};
    end
endfunction

`endif

// ==== test/fp_unit_tb.sv ====
`timescale 1ns/10ps
// Testbench for the binary16 APB coprocessor, normal operands only
// Random operands from an LCG seeded with 44, checked against the reference model
module fp_unit_tb;
    import fp_pkg::*;

    `include "fp_ref_model.svh"

    localparam int NUM_OPS    = 410;
    localparam int RST_CYCLES = 10;
    localparam int TIMEOUT_NS = NUM_OPS * 40 * 40 + RST_CYCLES * 40;

    logic              clk = 1'b0;
    logic              arst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;

    logic [31:0] rng_state = 32'd44;
    int          checks = 0;
    int          errors = 0;

    fp_unit dut_i (
        .clk(clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = lcg_next(rng_state);
        return rng_state;
    endfunction

    // Exponent field kept in 1..30
    function automatic fp16_t rand_operand();
        logic [31:0] r;
        logic [4:0]  e;
        r = next_rand();
        e = 5'(1 + r[31:16] % 30);
        return {r[15], e, r[14:5]};
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0d ns: %s, expected %h, got %h",
                     $time, what, expected, actual);
        end
    endtask

    // ============================================================
    // APB transfer, setup then access with wait states
    // ============================================================
    task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output int waits);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Full operation with polling, result and flags against the model
    task automatic do_op(input fp16_t a, input fp16_t b, input logic s,
                         output logic [31:0] st);
        logic [31:0] rd;
        logic        err;
        int          waits;
        fp16_t       er;
        logic        eo;
        logic        eu;
        logic        ez;
        ref_addsub(a, b, s, er, eo, eu, ez);
        apb_xfer(1'b1, ADDR_OPERANDS, {b, a}, rd, err, waits);
        check(32'(err), 32'd0, "pslverr on operand write");
        apb_xfer(1'b1, ADDR_CMD, {31'd0, s}, rd, err, waits);
        check(32'(err), 32'd0, "pslverr on command write");
        st = '0;
        while (!st[1]) begin
            apb_xfer(1'b0, ADDR_STATUS, '0, st, err, waits);
        end
        check(32'(st[4:2]), 32'({ez, eu, eo}),
              $sformatf("flags z/u/o for %h %s %h", a, s ? "-" : "+", b));
        apb_xfer(1'b0, ADDR_RESULT, '0, rd, err, waits);
        check(32'(rd[15:0]), 32'(er),
              $sformatf("result for %h %s %h", a, s ? "-" : "+", b));
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        fp16_t       a;
        fp16_t       b;
        fp16_t       er;
        logic        eo;
        logic        eu;
        logic        ez;
        logic [31:0] r;
        logic [31:0] rd;
        logic [31:0] st;
        logic [31:0] st2;
        logic        err;
        int          waits;
        int          eb;

        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        // Reset state
        @(negedge clk);
        check(32'(pready), 32'd1, "pready after reset");
        apb_xfer(1'b0, ADDR_STATUS, '0, st, err, waits);
        check(st, 32'd0, "STATUS after reset");

        // Random add and subtract, half with nearby exponents
        for (int i = 0; i < 400; i++) begin
            a = rand_operand();
            b = rand_operand();
            r = next_rand();
            if (r[20]) begin
                eb = int'(a[14:10]) + int'(r[7:0] % 5) - 2;
                eb = (eb < 1) ? 1 : ((eb > 30) ? 30 : eb);
                b[14:10] = 5'(eb);
            end
            do_op(a, b, r[24], st);
        end

        // Overflow, underflow and exact zero
        do_op(16'h7bff, 16'h7bff, 1'b0, st);
        do_op(16'h0401, 16'h0400, 1'b1, st);
        do_op(16'h3c00, 16'h3c00, 1'b1, st);

        // Stalled RESULT read right after the command
        ref_addsub(16'h4248, 16'hb555, 1'b0, er, eo, eu, ez);
        apb_xfer(1'b1, ADDR_OPERANDS, {16'hb555, 16'h4248}, rd, err, waits);
        apb_xfer(1'b1, ADDR_CMD, 32'd0, rd, err, waits);
        apb_xfer(1'b0, ADDR_RESULT, '0, rd, err, waits);
        check(32'(waits > 0), 32'd1, "RESULT read while busy was not stalled");
        check(32'(err), 32'd0, "pslverr on stalled RESULT read");
        check(32'(rd[15:0]), 32'(er), "stalled RESULT value");

        // Busy CMD write is rejected and the running add completes
        ref_addsub(16'h5a3c, 16'h4d11, 1'b0, er, eo, eu, ez);
        apb_xfer(1'b1, ADDR_OPERANDS, {16'h4d11, 16'h5a3c}, rd, err, waits);
        apb_xfer(1'b1, ADDR_CMD, 32'd0, rd, err, waits);
        apb_xfer(1'b1, ADDR_CMD, 32'd1, rd, err, waits);
        check(32'(err), 32'd1, "pslverr on CMD write while busy");
        st = '0;
        while (!st[1]) begin
            apb_xfer(1'b0, ADDR_STATUS, '0, st, err, waits);
        end
        apb_xfer(1'b0, ADDR_RESULT, '0, rd, err, waits);
        check(32'(rd[15:0]), 32'(er), "result after rejected CMD");
        apb_xfer(1'b0, ADDR_STATUS, '0, st, err, waits);
        check(32'(st[1:0]), 32'd0, "busy/done after rejected CMD");
        apb_xfer(1'b1, ADDR_STATUS, 32'hffff, rd, err, waits);
        check(32'(err), 32'd1, "pslverr on STATUS write");
        apb_xfer(1'b0, 4'h2, '0, rd, err, waits);
        check(32'(err), 32'd1, "pslverr on unmapped read");

        // Done clears on RESULT read, flags stay
        ref_addsub(16'hf800, 16'h7800, 1'b1, er, eo, eu, ez);
        do_op(16'hf800, 16'h7800, 1'b1, st);
        apb_xfer(1'b0, ADDR_STATUS, '0, st2, err, waits);
        check(32'(st2[1:0]), 32'd0, "busy/done after RESULT read");
        check(32'(st2[4:2]), 32'({ez, eu, eo}), "flags after RESULT read");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
